//--- src.f
rtl/fetch_pkg.sv
rtl/fetch_csr.sv
rtl/imem.sv
rtl/fetch_buffer.sv
rtl/fetch_stage.sv
rtl/fetch_top.sv
test/tb_fetch.sv

//--- test/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

    localparam int AW      = 8;
    localparam int WORDS   = 1 << AW;
    localparam int N_PLAIN = 150;
    localparam int N_MIXED = 300;
    localparam int N_BP    = 300;
    localparam int N_REDIR = 300;
    localparam int N_STOP  = 20;
    // 20 cycles per expected instruction plus room for image loads and csr traffic
    localparam int WATCHDOG_CYCLES =
        20 * (N_PLAIN + N_MIXED + N_BP + N_REDIR + N_STOP) + 4000;

    logic                 clk;
    logic                 reset_i;
    logic                 wb_cyc_i;
    logic                 wb_stb_i;
    logic                 wb_we_i;
    fetch_pkg::wb_addr_t  wb_adr_i;
    fetch_pkg::word_t     wb_dat_i;
    logic [3:0]           wb_sel_i;
    fetch_pkg::word_t     wb_dat_o;
    logic                 wb_ack_o;
    logic                 redirect_i;
    fetch_pkg::pc_t       redirect_pc_i;
    logic                 accept_i;
    fetch_pkg::word_t     instr_o;
    fetch_pkg::pc_t       instr_pc_o;
    logic                 instr_valid_o;

    // testbench copy of the memory image
    logic [31:0] mem_img [WORDS];

    logic [31:0] lfsr_q = 32'h3035_59d2;
    int          errors = 0;
    int          retired = 0;
    logic [31:0] exp_pc = '0;
    int          since_redirect = 1000;
    logic        prev_valid = 1'b0;
    logic        prev_accept = 1'b0;
    logic [31:0] prev_instr = '0;
    logic [31:0] prev_pc = '0;
    logic [63:0] ref_q;
    int          err_start;
    int          waited;

    fetch_top #(
        .IMEM_AW (AW)
    ) i_fetch_top (
        .clk           (clk),
        .reset_i       (reset_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_sel_i      (wb_sel_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .accept_i      (accept_i),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .instr_valid_o (instr_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ======================================================================
    // random numbers and reference model
    // ======================================================================

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[31]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    // parcel at a byte address wrapping at the memory size
    function automatic logic [15:0] parcel_at(input logic [31:0] pc);
        logic [31:0] w;
        w = mem_img[pc[AW+1:2]];
        return pc[1] ? w[31:16] : w[15:0];
    endfunction

    // {next pc, instruction}
    // low bits 11 mean two parcels and anything else one zero-extended parcel
    function automatic logic [63:0] ref_instr(input logic [31:0] pc);
        logic [15:0] p0;
        logic [15:0] p1;
        p0 = parcel_at(pc);
        p1 = parcel_at(pc + 32'd2);
        if (p0[1:0] == 2'b11) begin
            return {pc + 32'd4, p1, p0};
        end
        return {pc + 32'd2, 16'h0000, p0};
    endfunction

    // ======================================================================
    // comparing process
    // ======================================================================

    always @(posedge clk) begin
        if (!reset_i) begin
            if (redirect_i) begin
                since_redirect = 0;
            end else if (since_redirect < 1000) begin
                since_redirect++;
            end
            // nop while nothing valid
            if (instr_valid_o !== 1'b1 && instr_o !== fetch_pkg::INSTR_NOP) begin
                $display("error: instr_o is %h while invalid, expected %h",
                         instr_o, fetch_pkg::INSTR_NOP);
                errors++;
            end
            if (instr_valid_o && since_redirect < 3) begin
                $display("instruction valid only %0d cycles after redirect", since_redirect);
                errors++;
            end
            // outputs hold under back-pressure
            if (prev_valid && !prev_accept && instr_valid_o) begin
                if (instr_o !== prev_instr) begin
                    $display("error: instr_o changed while stalled, %h -> %h",
                             prev_instr, instr_o);
                    errors++;
                end
                if (instr_pc_o !== prev_pc) begin
                    $display("error: instr_pc_o changed while stalled, %h -> %h",
                             prev_pc, instr_pc_o);
                    errors++;
                end
            end
            // retire
            if (instr_valid_o && accept_i) begin
                ref_q = ref_instr(exp_pc);
                if (instr_pc_o !== exp_pc) begin
                    $display("error: instr_pc_o is %h, expected %h", instr_pc_o, exp_pc);
                    errors++;
                end
                if (instr_o !== ref_q[31:0]) begin
                    $display("error: instr_o is %h, expected %h at pc %h",
                             instr_o, ref_q[31:0], exp_pc);
                    errors++;
                end
                exp_pc = ref_q[63:32];
                retired++;
            end
            if (redirect_i) begin
                exp_pc = redirect_pc_i;
            end
            prev_valid  = instr_valid_o;
            prev_accept = accept_i;
            prev_instr  = instr_o;
            prev_pc     = instr_pc_o;
        end
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    // ======================================================================
    // wishbone master
    // ======================================================================

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
        int n;
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b1;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = sel;
        n = 0;
        // hold until ack
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack_o && n < 20);
        if (!wb_ack_o) begin
            $display("no acknowledge for write to offset %h", adr);
            errors++;
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
        int n;
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = 1'b0;
        wb_adr_i = adr;
        wb_sel_i = 4'hf;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack_o && n < 20);
        if (!wb_ack_o) begin
            $display("no acknowledge for read of offset %h", adr);
            errors++;
        end
        dat      = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
    endtask

    task automatic check_read(input logic [3:0] adr, input logic [31:0] expected);
        logic [31:0] got;
        wb_read(adr, got);
        if (got !== expected) begin
            $display("error: wb_dat_o at offset %h is %h, expected %h", adr, got, expected);
            errors++;
        end
    endtask

    // ======================================================================
    // images and stream control
    // ======================================================================

    // plain 32-bit words with a pattern built from the whole word address
    task automatic fill_plain();
        logic [7:0] a;
        for (int w = 0; w < WORDS; w++) begin
            a = 8'(w);
            mem_img[w] = {a, a ^ 8'h5a, a * 8'd7 + 8'd1, a[5:0], 2'b11};
        end
    endtask

    task automatic set_parcel(input int idx, input logic [15:0] v);
        if (idx % 2 == 1) begin
            mem_img[idx / 2][31:16] = v;
        end else begin
            mem_img[idx / 2][15:0] = v;
        end
    endtask

    // random mix of compressed and wide parcels where wide ones straddle words freely
    task automatic fill_mixed();
        int p;
        logic [15:0] lo;
        logic [15:0] hi;
        p = 0;
        while (p < 2 * WORDS) begin
            if (rand_bits(1) != 0 && p < 2 * WORDS - 1) begin
                lo = 16'(rand_bits(16));
                lo[1:0] = 2'b11;
                hi = 16'(rand_bits(16));
                set_parcel(p, lo);
                set_parcel(p + 1, hi);
                p += 2;
            end else begin
                lo = 16'(rand_bits(16));
                if (lo[1:0] == 2'b11) begin
                    lo[1:0] = 2'b01;
                end
                set_parcel(p, lo);
                p += 1;
            end
        end
    endtask

    // address window then auto-incrementing data writes
    task automatic load_image();
        wb_write(fetch_pkg::CSR_IMEM_ADDR, 32'h0, 4'hf);
        for (int w = 0; w < WORDS; w++) begin
            wb_write(fetch_pkg::CSR_IMEM_DATA, mem_img[w], 4'hf);
        end
    endtask

    task automatic start_run(input logic [31:0] boot);
        exp_pc = boot;
        wb_write(fetch_pkg::CSR_BOOT_PC, boot, 4'hf);
        wb_write(fetch_pkg::CSR_CTRL, 32'h1, 4'hf);
    endtask

    task automatic stop_run();
        accept_i = 1'b0;
        wb_write(fetch_pkg::CSR_CTRL, 32'h0, 4'hf);
    endtask

    // retire n instructions with optional random accept and redirects
    task automatic stream(input int n, input bit rand_accept, input bit with_redirect);
        int base;
        int cycles;
        int gap;
        base   = retired;
        cycles = 0;
        gap    = 6;
        while (retired - base < n && cycles < 20 * n + 100) begin
            @(negedge clk);
            cycles++;
            accept_i = rand_accept ? (rand_bits(1) != 0) : 1'b1;
            if (with_redirect) begin
                if (redirect_i) begin
                    redirect_i = 1'b0;
                end else if (retired - base >= 2 && gap == 0) begin
                    redirect_i    = 1'b1;
                    redirect_pc_i = rand_bits(9) << 1;
                    gap           = 4 + rand_bits(4);
                end else if (gap > 0) begin
                    gap--;
                end
            end
        end
        accept_i   = 1'b0;
        redirect_i = 1'b0;
        if (retired - base < n) begin
            $display("timeout, only %0d of %0d instructions retired", retired - base, n);
            errors++;
        end
    endtask

    task automatic report(input int num, input string name, input int err_before);
        $display("test %0d %s: %s, %0d errors, %0d retired so far", num, name,
                 (errors == err_before) ? "ok" : "bad", errors - err_before, retired);
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================

    initial begin
        reset_i       = 1'b1;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        wb_we_i       = 1'b0;
        wb_adr_i      = '0;
        wb_dat_i      = '0;
        wb_sel_i      = '0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        accept_i      = 1'b0;
        repeat (10) @(negedge clk);
        reset_i = 1'b0;

        // memory defined before anything fetches
        fill_plain();
        load_image();

        // csr readback with byte selects
        err_start = errors;
        wb_write(fetch_pkg::CSR_BOOT_PC, 32'h1122_3344, 4'hf);
        check_read(fetch_pkg::CSR_BOOT_PC, 32'h1122_3344);
        wb_write(fetch_pkg::CSR_BOOT_PC, 32'haabb_ccde, 4'b0101);
        check_read(fetch_pkg::CSR_BOOT_PC, 32'h11bb_33de);
        wb_write(fetch_pkg::CSR_BOOT_PC, 32'h0, 4'b0000);
        check_read(fetch_pkg::CSR_BOOT_PC, 32'h11bb_33de);
        wb_write(fetch_pkg::CSR_IMEM_ADDR, 32'h0000_00a5, 4'hf);
        check_read(fetch_pkg::CSR_IMEM_ADDR, 32'h0000_00a5);
        wb_write(fetch_pkg::CSR_IMEM_ADDR, 32'hffff_ff3c, 4'b0001);
        check_read(fetch_pkg::CSR_IMEM_ADDR, 32'h0000_003c);
        check_read(fetch_pkg::CSR_IMEM_DATA, 32'h0);
        wb_write(fetch_pkg::CSR_CTRL, 32'h1, 4'b0000);
        check_read(fetch_pkg::CSR_CTRL, 32'h0);
        wb_write(fetch_pkg::CSR_CTRL, 32'h1, 4'b0001);
        check_read(fetch_pkg::CSR_CTRL, 32'h1);
        wb_write(fetch_pkg::CSR_CTRL, 32'h0, 4'b0001);
        check_read(fetch_pkg::CSR_CTRL, 32'h0);
        report(1, "csr readback", err_start);

        // straight 32-bit code, steps of 4
        err_start = errors;
        start_run(32'h0000_0100);
        stream(N_PLAIN, 1'b0, 1'b0);
        stop_run();
        report(2, "plain 32-bit stream", err_start);

        // odd boot pc drops the low parcel of the first word
        err_start = errors;
        fill_mixed();
        load_image();
        start_run(32'h0000_0002);
        stream(N_MIXED, 1'b0, 1'b0);
        stop_run();
        report(3, "mixed compressed stream", err_start);

        err_start = errors;
        start_run(32'h0000_01f6);
        stream(N_BP, 1'b1, 1'b0);
        stop_run();
        report(4, "back-pressure", err_start);

        err_start = errors;
        start_run(32'h0000_0010);
        stream(N_REDIR, 1'b0, 1'b1);
        stop_run();
        report(5, "redirect", err_start);

        // clear run while instructions flow
        err_start = errors;
        start_run(32'h0000_0080);
        stream(N_STOP, 1'b0, 1'b0);
        accept_i = 1'b1;
        wb_write(fetch_pkg::CSR_CTRL, 32'h0, 4'hf);
        waited = 0;
        while (instr_valid_o && waited < 2) begin
            @(negedge clk);
            waited++;
        end
        if (instr_valid_o) begin
            $display("instr_valid_o still high two cycles after run was cleared");
            errors++;
        end
        waited = 0;
        repeat (8) begin
            @(negedge clk);
            if (instr_valid_o) begin
                waited++;
            end
        end
        if (waited != 0) begin
            $display("instr_valid_o came back while run was cleared");
            errors++;
        end
        accept_i = 1'b0;
        report(6, "stop", err_start);

        $display("6 tests, %0d instructions checked, %0d errors", retired, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int IMEM_AW = 8
) (
    input  logic                 clk,
    input  logic                 reset_i,
    // wishbone classic slave
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  fetch_pkg::wb_addr_t  wb_adr_i,
    input  fetch_pkg::word_t     wb_dat_i,
    input  logic [3:0]           wb_sel_i,
    output fetch_pkg::word_t     wb_dat_o,
    output logic                 wb_ack_o,
    // decode stage
    input  logic                 redirect_i,
    input  fetch_pkg::pc_t       redirect_pc_i,
    input  logic                 accept_i,
    output fetch_pkg::word_t     instr_o,
    output fetch_pkg::pc_t       instr_pc_o,
    output logic                 instr_valid_o
);

    // csr to stage and memory
    logic                 run;
    fetch_pkg::pc_t       boot_pc;
    logic                 imem_we;
    logic [IMEM_AW-1:0]   imem_waddr;
    fetch_pkg::word_t     imem_wdata;

    // buffer to memory
    logic                 rd_en;
    logic [IMEM_AW-1:0]   rd_addr;
    fetch_pkg::word_t     rd_data;

    // stage to buffer
    logic [2:0]           count;
    fetch_pkg::half_t     head0;
    fetch_pkg::half_t     head1;
    logic [1:0]           drain;
    logic                 restart;
    fetch_pkg::pc_t       restart_pc;

    fetch_csr #(
        .IMEM_AW (IMEM_AW)
    ) i_fetch_csr (
        .clk          (clk),
        .reset_i      (reset_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_sel_i     (wb_sel_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .run_o        (run),
        .boot_pc_o    (boot_pc),
        .imem_we_o    (imem_we),
        .imem_waddr_o (imem_waddr),
        .imem_wdata_o (imem_wdata)
    );

    imem #(
        .IMEM_AW (IMEM_AW)
    ) i_imem (
        .clk       (clk),
        .we_i      (imem_we),
        .waddr_i   (imem_waddr),
        .wdata_i   (imem_wdata),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    fetch_buffer #(
        .IMEM_AW (IMEM_AW)
    ) i_fetch_buffer (
        .clk          (clk),
        .reset_i      (reset_i),
        .restart_i    (restart),
        .restart_pc_i (restart_pc),
        .drain_i      (drain),
        .count_o      (count),
        .head0_o      (head0),
        .head1_o      (head1),
        .rd_en_o      (rd_en),
        .rd_addr_o    (rd_addr),
        .rd_data_i    (rd_data)
    );

    fetch_stage i_fetch_stage (
        .clk           (clk),
        .reset_i       (reset_i),
        .run_i         (run),
        .boot_pc_i     (boot_pc),
        .count_i       (count),
        .head0_i       (head0),
        .head1_i       (head1),
        .drain_o       (drain),
        .restart_o     (restart),
        .restart_pc_o  (restart_pc),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .accept_i      (accept_i),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .instr_valid_o (instr_valid_o)
    );

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                 clk,
    input  logic                 reset_i,
    // levels from the csr block
    input  logic                 run_i,
    input  fetch_pkg::pc_t       boot_pc_i,
    // buffer side
    input  logic [2:0]           count_i,
    input  fetch_pkg::half_t     head0_i,
    input  fetch_pkg::half_t     head1_i,
    output logic [1:0]           drain_o,
    output logic                 restart_o,
    output fetch_pkg::pc_t       restart_pc_o,
    // decode side
    input  logic                 redirect_i,
    input  fetch_pkg::pc_t       redirect_pc_i,
    input  logic                 accept_i,
    output fetch_pkg::word_t     instr_o,
    output fetch_pkg::pc_t       instr_pc_o,
    output logic                 instr_valid_o
);

    fetch_pkg::fetch_state_e state_q;
    fetch_pkg::fetch_state_e state_d;
    fetch_pkg::pc_t          pc_q;
    fetch_pkg::pc_t          pc_d;

    logic                    is_wide;
    logic [1:0]              need;
    logic                    avail;
    logic                    valid;
    fetch_pkg::word_t        instr_raw;

    // ======================================================================
    // alignment
    // ======================================================================

    // low bits 11 mean a 32-bit instruction and anything else is compressed
    assign is_wide = (head0_i[1:0] == 2'b11);
    assign need    = is_wide ? 2'd2 : 2'd1;
    // wide needs two parcels and compressed needs one
    assign avail   = (count_i >= 3'd2) | ((count_i != 3'd0) & ~is_wide);

    // compressed parcel zero extended
    assign instr_raw = is_wide ? {head1_i, head0_i} : {16'h0000, head0_i};

    // ======================================================================
    // state machine
    // ======================================================================

    always_comb begin
        state_d      = state_q;
        pc_d         = pc_q;
        restart_o    = 1'b0;
        restart_pc_o = pc_q;
        drain_o      = 2'd0;
        valid        = 1'b0;
        case (state_q)
            fetch_pkg::FS_IDLE: begin
                if (run_i) begin
                    state_d = fetch_pkg::FS_START;
                end
            end
            fetch_pkg::FS_START: begin
                // point buffer at the boot address
                restart_o    = 1'b1;
                restart_pc_o = {boot_pc_i[31:1], 1'b0};
                pc_d         = {boot_pc_i[31:1], 1'b0};
                state_d      = fetch_pkg::FS_RUN;
            end
            fetch_pkg::FS_RUN: begin
                if (!run_i) begin
                    // stop, flush and park
                    restart_o = 1'b1;
                    state_d   = fetch_pkg::FS_IDLE;
                end else if (redirect_i) begin
                    // redirect wins over accept
                    restart_o    = 1'b1;
                    restart_pc_o = {redirect_pc_i[31:1], 1'b0};
                    pc_d         = {redirect_pc_i[31:1], 1'b0};
                end else begin
                    valid = avail;
                    if (avail && accept_i) begin
                        drain_o = need;
                        pc_d    = pc_q + (is_wide ? 32'd4 : 32'd2);
                    end
                end
            end
            default: begin
                state_d = fetch_pkg::FS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= fetch_pkg::FS_IDLE;
            pc_q    <= '0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    // nop whenever nothing valid is presented
    assign instr_o       = valid ? instr_raw : fetch_pkg::INSTR_NOP;
    assign instr_pc_o    = pc_q;
    assign instr_valid_o = valid;

endmodule

`default_nettype wire

//--- rtl/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer #(
    parameter int IMEM_AW = 8
) (
    input  logic                clk,
    input  logic                reset_i,
    // restart from the fetch stage
    input  logic                restart_i,
    input  fetch_pkg::pc_t      restart_pc_i,
    // drain side
    input  logic [1:0]          drain_i,
    output logic [2:0]          count_o,
    output fetch_pkg::half_t    head0_o,
    output fetch_pkg::half_t    head1_o,
    // imem read port
    output logic                rd_en_o,
    output logic [IMEM_AW-1:0]  rd_addr_o,
    input  fetch_pkg::word_t    rd_data_i
);

    localparam int QN = 5;

    // parcel storage
    fetch_pkg::half_t    q_mem [QN];

    logic [2:0]          rd_ptr_q;
    logic [2:0]          count_q;
    logic [IMEM_AW-1:0]  fetch_addr_q;
    logic                inflight_q;
    logic                active_q;
    logic                drop_low_q;

    logic [3:0]          committed;
    logic                rd_fire;
    logic                push_en;
    logic [2:0]          push_n;
    logic [2:0]          wr_ptr;
    fetch_pkg::half_t    push0;
    fetch_pkg::half_t    push1;

    // pointer add modulo five
    function automatic logic [2:0] wrap5(
        input logic [2:0] base,
        input logic [2:0] off
    );
        logic [3:0] s;
        s = {1'b0, base} + {1'b0, off};
        if (s >= 4'd5) begin
            s = s - 4'd5;
        end
        return s[2:0];
    endfunction

    // ======================================================================
    // read issue
    // ======================================================================

    // parcels held plus two for a word still on its way
    assign committed = {1'b0, count_q} + (inflight_q ? 4'd2 : 4'd0);

    // at least two free slots left, nothing issued in a restart cycle
    assign rd_fire = active_q & ~restart_i & (committed <= 4'd3);

    assign rd_en_o   = rd_fire;
    assign rd_addr_o = fetch_addr_q;

    // ======================================================================
    // push of a returning word
    // ======================================================================

    // a word landing in a restart cycle is stale, dropped
    assign push_en = inflight_q & ~restart_i;

    // odd restart target skips the low parcel of first word
    assign push_n = !push_en   ? 3'd0 :
                    drop_low_q ? 3'd1 : 3'd2;
    assign push0  = drop_low_q ? rd_data_i[31:16] : rd_data_i[15:0];
    assign push1  = rd_data_i[31:16];

    // tail slot, behind the parcels still held
    assign wr_ptr = wrap5(rd_ptr_q, count_q);

    always_ff @(posedge clk) begin
        if (push_n != 3'd0) begin
            q_mem[wr_ptr] <= push0;
        end
        if (push_n == 3'd2) begin
            q_mem[wrap5(wr_ptr, 3'd1)] <= push1;
        end
    end

    // ======================================================================
    // pointers, count, fetch address
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_ptr_q     <= '0;
            count_q      <= '0;
            fetch_addr_q <= '0;
            inflight_q   <= 1'b0;
            active_q     <= 1'b0;
            drop_low_q   <= 1'b0;
        end else begin
            inflight_q <= rd_fire;
            if (restart_i) begin
                // flush queue, refetch from word holding the target
                active_q     <= 1'b1;
                rd_ptr_q     <= '0;
                count_q      <= '0;
                fetch_addr_q <= restart_pc_i[IMEM_AW+1:2];
                drop_low_q   <= restart_pc_i[1];
            end else begin
                // push and drain may overlap
                rd_ptr_q <= wrap5(rd_ptr_q, {1'b0, drain_i});
                count_q  <= count_q + push_n - {1'b0, drain_i};
                if (rd_fire) begin
                    fetch_addr_q <= fetch_addr_q + 1'b1;
                end
                if (push_en) begin
                    drop_low_q <= 1'b0;
                end
            end
        end
    end

    // two oldest parcels
    assign count_o = count_q;
    assign head0_o = q_mem[rd_ptr_q];
    assign head1_o = q_mem[wrap5(rd_ptr_q, 3'd1)];

endmodule

`default_nettype wire

//--- rtl/imem.sv
`timescale 1ns/1ps
`default_nettype none

module imem #(
    parameter int IMEM_AW = 8
) (
    input  logic                clk,
    // load port from csr block
    input  logic                we_i,
    input  logic [IMEM_AW-1:0]  waddr_i,
    input  fetch_pkg::word_t    wdata_i,
    // fetch read port
    input  logic                rd_en_i,
    input  logic [IMEM_AW-1:0]  rd_addr_i,
    output fetch_pkg::word_t    rd_data_o
);

    localparam int DEPTH = 1 << IMEM_AW;

    // word storage
    fetch_pkg::word_t mem_q [DEPTH];
    fetch_pkg::word_t rd_q;

    // load path, one word per csr data write
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // synchronous read like an sram macro
    // data valid the cycle after rd_en, held until next read
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_q <= mem_q[rd_addr_i];
        end
    end

    assign rd_data_o = rd_q;

endmodule

`default_nettype wire

//--- rtl/fetch_csr.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_csr #(
    parameter int IMEM_AW = 8
) (
    input  logic                 clk,
    input  logic                 reset_i,
    // wishbone classic slave
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  fetch_pkg::wb_addr_t  wb_adr_i,
    input  fetch_pkg::word_t     wb_dat_i,
    input  logic [3:0]           wb_sel_i,
    output fetch_pkg::word_t     wb_dat_o,
    output logic                 wb_ack_o,
    // levels to the fetch stage
    output logic                 run_o,
    output fetch_pkg::pc_t       boot_pc_o,
    // imem load port
    output logic                 imem_we_o,
    output logic [IMEM_AW-1:0]   imem_waddr_o,
    output fetch_pkg::word_t     imem_wdata_o
);

    logic                 req;
    logic                 ack_q;
    logic                 run_q;
    fetch_pkg::pc_t       boot_pc_q;
    logic [IMEM_AW-1:0]   imem_addr_q;
    logic                 imem_we_q;
    logic [IMEM_AW-1:0]   imem_waddr_q;
    fetch_pkg::word_t     imem_wdata_q;
    fetch_pkg::word_t     dat_q;
    fetch_pkg::word_t     ctrl_rd;
    fetch_pkg::word_t     addr_rd;
    fetch_pkg::word_t     rd_mux;
    fetch_pkg::word_t     ctrl_new;
    fetch_pkg::word_t     boot_new;
    fetch_pkg::word_t     addr_new;

    // merge the selected bytes of a write into the old value
    function automatic fetch_pkg::word_t merge_bytes(
        input fetch_pkg::word_t old_v,
        input fetch_pkg::word_t new_v,
        input logic [3:0]       sel
    );
        fetch_pkg::word_t res;
        res = old_v;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return res;
    endfunction

    // new request, ack low in between two accesses
    assign req = wb_cyc_i & wb_stb_i & ~ack_q;

    // register views as seen on the bus
    assign ctrl_rd = {31'd0, run_q};
    assign addr_rd = fetch_pkg::word_t'(imem_addr_q);

    assign ctrl_new = merge_bytes(ctrl_rd, wb_dat_i, wb_sel_i);
    assign boot_new = merge_bytes(boot_pc_q, wb_dat_i, wb_sel_i);
    assign addr_new = merge_bytes(addr_rd, wb_dat_i, wb_sel_i);

    always_comb begin
        case (wb_adr_i)
            fetch_pkg::CSR_CTRL:      rd_mux = ctrl_rd;
            fetch_pkg::CSR_BOOT_PC:   rd_mux = boot_pc_q;
            fetch_pkg::CSR_IMEM_ADDR: rd_mux = addr_rd;
            // data window is write only
            default:                  rd_mux = '0;
        endcase
    end

    // ======================================================================
    // control registers
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q       <= 1'b0;
            run_q       <= 1'b0;
            boot_pc_q   <= '0;
            imem_addr_q <= '0;
            imem_we_q   <= 1'b0;
        end else begin
            ack_q     <= req;
            imem_we_q <= 1'b0;
            if (req && wb_we_i) begin
                case (wb_adr_i)
                    fetch_pkg::CSR_CTRL:      run_q <= ctrl_new[0];
                    // keep boot pc halfword aligned
                    fetch_pkg::CSR_BOOT_PC:   boot_pc_q <= {boot_new[31:1], 1'b0};
                    fetch_pkg::CSR_IMEM_ADDR: imem_addr_q <= addr_new[IMEM_AW-1:0];
                    fetch_pkg::CSR_IMEM_DATA: begin
                        // one memory write, then step to next word
                        imem_we_q   <= 1'b1;
                        imem_addr_q <= imem_addr_q + 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // read data and memory write payload
    always_ff @(posedge clk) begin
        if (req && !wb_we_i) begin
            dat_q <= rd_mux;
        end
        if (req && wb_we_i) begin
            imem_waddr_q <= imem_addr_q;
            // full word always, byte selects ignored here
            imem_wdata_q <= wb_dat_i;
        end
    end

    assign wb_ack_o     = ack_q;
    assign wb_dat_o     = dat_q;
    assign run_o        = run_q;
    assign boot_pc_o    = boot_pc_q;
    assign imem_we_o    = imem_we_q;
    assign imem_waddr_o = imem_waddr_q;
    assign imem_wdata_o = imem_wdata_q;

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // ======================================================================
    // widths with a meaning
    // ======================================================================

    // instruction memory word, or a full 32-bit instruction
    typedef logic [31:0] word_t;

    // one 16-bit instruction parcel
    typedef logic [15:0] half_t;

    // byte address, bit 0 always zero
    typedef logic [31:0] pc_t;

    // wishbone byte offset inside the csr window
    typedef logic [3:0] wb_addr_t;

    // ======================================================================
    // constants
    // ======================================================================

    // addi x0, x0, 0
    localparam word_t INSTR_NOP = 32'h0000_0013;

    // csr register map
    localparam wb_addr_t CSR_CTRL      = 4'h0;
    localparam wb_addr_t CSR_BOOT_PC   = 4'h4;
    localparam wb_addr_t CSR_IMEM_ADDR = 4'h8;
    localparam wb_addr_t CSR_IMEM_DATA = 4'hC;

    // fetch stage FSM
    typedef enum logic [1:0] {
        FS_IDLE  = 2'd0,
        FS_START = 2'd1,
        FS_RUN   = 2'd2
    } fetch_state_e;

endpackage

`default_nettype wire
